// ==== verilog/mesh_router_macros.svh ====
`ifndef MESH_ROUTER_MACROS_SVH
`define MESH_ROUTER_MACROS_SVH

// Router ports: Local, North, East, South, West
`define MR_NUM_PORTS 5

// One mesh coordinate, X or Y
`define MR_COORD_W 3

// Flit data
`define MR_PAYLOAD_W 16

`endif

// ==== verilog/mesh_router_pkg.sv ====
`include "mesh_router_macros.svh"

package mesh_router_pkg;

   ////////////////////////////////////////
   // Vector types
   ////////////////////////////////////////

   typedef logic [`MR_COORD_W-1:0]   coord_t;
   typedef logic [`MR_PAYLOAD_W-1:0] payload_t;

   // One bit per router port
   typedef logic [`MR_NUM_PORTS-1:0] port_vec_t;
   typedef logic [2:0]               port_idx_t;

   // Port numbering
   localparam port_idx_t PORT_LOCAL = 3'd0;
   localparam port_idx_t PORT_NORTH = 3'd1;
   localparam port_idx_t PORT_EAST  = 3'd2;
   localparam port_idx_t PORT_SOUTH = 3'd3;
   localparam port_idx_t PORT_WEST  = 3'd4;

   ////////////////////////////////////////
   // Flit and arbiter state
   ////////////////////////////////////////

   // Destination only valid on a head flit
   typedef struct packed {
      logic     head;
      logic     tail;
      coord_t   dst_x;
      coord_t   dst_y;
      payload_t payload;
   } flit_t;

   // One-hot, idle is all zero
   typedef enum logic [`MR_NUM_PORTS-1:0] {
      ARB_IDLE = 5'b00000,
      ARB_GNT0 = 5'b00001,
      ARB_GNT1 = 5'b00010,
      ARB_GNT2 = 5'b00100,
      ARB_GNT3 = 5'b01000,
      ARB_GNT4 = 5'b10000
   } arb_state_t;

endpackage

// ==== verilog/output_arbiter.sv ====
`timescale 1ns/1ps
`include "mesh_router_macros.svh"

module output_arbiter
(
   input  logic                       clk,
   input  logic                       rst,
   input  mesh_router_pkg::port_vec_t req,
   output mesh_router_pkg::port_vec_t gnt
);

   import mesh_router_pkg::*;

   arb_state_t state;
   arb_state_t next_state;

   always_ff @(posedge clk)
   begin
      if (rst)
         state <= ARB_IDLE;
      else
         state <= next_state;
   end

   ////////////////////////////////////////
   // Next state
   ////////////////////////////////////////

   always_comb
   begin
      next_state = ARB_IDLE;
      case (state)
         // Lowest input index wins
         ARB_IDLE:
         begin
            if (req[0])
               next_state = ARB_GNT0;
            else if (req[1])
               next_state = ARB_GNT1;
            else if (req[2])
               next_state = ARB_GNT2;
            else if (req[3])
               next_state = ARB_GNT3;
            else if (req[4])
               next_state = ARB_GNT4;
         end
         // Hold while the owner keeps requesting
         ARB_GNT0:
         begin
            if (req[0])
               next_state = ARB_GNT0;
         end
         ARB_GNT1:
         begin
            if (req[1])
               next_state = ARB_GNT1;
         end
         ARB_GNT2:
         begin
            if (req[2])
               next_state = ARB_GNT2;
         end
         ARB_GNT3:
         begin
            if (req[3])
               next_state = ARB_GNT3;
         end
         ARB_GNT4:
         begin
            if (req[4])
               next_state = ARB_GNT4;
         end
         default:
            next_state = ARB_IDLE;
      endcase
   end

   // Grant decoded from state only
   always_comb
   begin
      gnt = '0;
      case (state)
         ARB_GNT0: gnt[0] = 1'b1;
         ARB_GNT1: gnt[1] = 1'b1;
         ARB_GNT2: gnt[2] = 1'b1;
         ARB_GNT3: gnt[3] = 1'b1;
         ARB_GNT4: gnt[4] = 1'b1;
         default:  gnt = '0;
      endcase
   end

endmodule

// ==== verilog/route_compute.sv ====
`timescale 1ns/1ps
`include "mesh_router_macros.svh"

module route_compute
#(
   parameter mesh_router_pkg::coord_t x_pos = '0,
   parameter mesh_router_pkg::coord_t y_pos = '0
)
(
   input  logic                       clk,
   input  logic                       rst,
   input  mesh_router_pkg::port_vec_t in_valid,
   input  mesh_router_pkg::flit_t     in_flit [`MR_NUM_PORTS],
   input  mesh_router_pkg::port_vec_t in_taken,
   output mesh_router_pkg::port_vec_t req_matrix [`MR_NUM_PORTS]
);

   import mesh_router_pkg::*;

   // Held route of the packet in progress, per input
   port_idx_t route_q [`MR_NUM_PORTS];
   port_vec_t busy_q;

   port_idx_t head_port [`MR_NUM_PORTS];
   port_idx_t cur_port  [`MR_NUM_PORTS];

   // X first, then Y, Local when both match
   function automatic port_idx_t xy_route(input coord_t dst_x, input coord_t dst_y);
      port_idx_t dir;
      if (dst_x > x_pos)
         dir = PORT_EAST;
      else if (dst_x < x_pos)
         dir = PORT_WEST;
      else if (dst_y > y_pos)
         dir = PORT_NORTH;
      else if (dst_y < y_pos)
         dir = PORT_SOUTH;
      else
         dir = PORT_LOCAL;
      return dir;
   endfunction

   always_comb
   begin
      for (int i = 0; i < `MR_NUM_PORTS; i++)
      begin
         head_port[i] = xy_route(in_flit[i].dst_x, in_flit[i].dst_y);
         cur_port[i]  = busy_q[i] ? route_q[i] : head_port[i];
      end
   end

   // Row o, bit i: input i wants output o
   always_comb
   begin
      for (int o = 0; o < `MR_NUM_PORTS; o++)
      begin
         for (int i = 0; i < `MR_NUM_PORTS; i++)
         begin
            req_matrix[o][i] = in_valid[i] && (cur_port[i] == port_idx_t'(o));
         end
      end
   end

   ////////////////////////////////////////
   // Packet tracking
   ////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         busy_q <= '0;
      end
      else
      begin
         for (int i = 0; i < `MR_NUM_PORTS; i++)
         begin
            if (in_valid[i] && in_taken[i])
            begin
               if (in_flit[i].tail)
                  busy_q[i] <= 1'b0;
               else if (in_flit[i].head)
                  busy_q[i] <= 1'b1;
            end
         end
      end
   end

   // Route latched from a multi-flit head
   always_ff @(posedge clk)
   begin
      for (int i = 0; i < `MR_NUM_PORTS; i++)
      begin
         if (in_taken[i] && in_flit[i].head && !in_flit[i].tail)
            route_q[i] <= head_port[i];
      end
   end

endmodule

// ==== verilog/switch_traversal.sv ====
`timescale 1ns/1ps
`include "mesh_router_macros.svh"

module switch_traversal
(
   input  logic                       clk,
   input  logic                       rst,
   input  mesh_router_pkg::flit_t     in_flit    [`MR_NUM_PORTS],
   input  mesh_router_pkg::port_vec_t req_matrix [`MR_NUM_PORTS],
   input  mesh_router_pkg::port_vec_t gnt_matrix [`MR_NUM_PORTS],
   output mesh_router_pkg::port_vec_t in_taken,
   output mesh_router_pkg::port_vec_t out_valid,
   output mesh_router_pkg::flit_t     out_flit   [`MR_NUM_PORTS]
);

   import mesh_router_pkg::*;

   // Request and grant together, per output
   port_vec_t match [`MR_NUM_PORTS];
   flit_t     sel_flit [`MR_NUM_PORTS];
   port_vec_t sel_valid;

   always_comb
   begin
      for (int o = 0; o < `MR_NUM_PORTS; o++)
      begin
         match[o] = req_matrix[o] & gnt_matrix[o];
      end
   end

   ////////////////////////////////////////
   // Crossbar
   ////////////////////////////////////////

   // At most one match per row
   always_comb
   begin
      for (int o = 0; o < `MR_NUM_PORTS; o++)
      begin
         sel_flit[o]  = '0;
         sel_valid[o] = |match[o];
         for (int i = 0; i < `MR_NUM_PORTS; i++)
         begin
            if (match[o][i])
               sel_flit[o] = in_flit[i];
         end
      end
   end

   // An input is taken by whichever output matched it
   always_comb
   begin
      in_taken = '0;
      for (int o = 0; o < `MR_NUM_PORTS; o++)
      begin
         in_taken = in_taken | match[o];
      end
   end

   ////////////////////////////////////////
   // Output registers
   ////////////////////////////////////////

   always_ff @(posedge clk)
   begin
      if (rst)
         out_valid <= '0;
      else
         out_valid <= sel_valid;
   end

   always_ff @(posedge clk)
   begin
      for (int o = 0; o < `MR_NUM_PORTS; o++)
      begin
         if (sel_valid[o])
            out_flit[o] <= sel_flit[o];
      end
   end

endmodule

// ==== verilog/mesh_router.sv ====
`timescale 1ns/1ps
`include "mesh_router_macros.svh"

module mesh_router
#(
   parameter mesh_router_pkg::coord_t x_pos = '0,
   parameter mesh_router_pkg::coord_t y_pos = '0
)
(
   input  logic                       clk,
   input  logic                       rst,
   input  mesh_router_pkg::port_vec_t in_valid,
   input  mesh_router_pkg::flit_t     in_flit  [`MR_NUM_PORTS],
   output mesh_router_pkg::port_vec_t in_taken,
   output mesh_router_pkg::port_vec_t out_valid,
   output mesh_router_pkg::flit_t     out_flit [`MR_NUM_PORTS]
);

   import mesh_router_pkg::*;

   // Indexed by output, one bit per input
   port_vec_t req_matrix [`MR_NUM_PORTS];
   port_vec_t gnt_matrix [`MR_NUM_PORTS];

   route_compute
   #(
      .x_pos (x_pos),
      .y_pos (y_pos)
   )
   i_route_compute
   (
      .clk        (clk),
      .rst        (rst),
      .in_valid   (in_valid),
      .in_flit    (in_flit),
      .in_taken   (in_taken),
      .req_matrix (req_matrix)
   );

   // One arbiter per output port
   for (genvar o = 0; o < `MR_NUM_PORTS; o++)
   begin : g_arb
      output_arbiter i_output_arbiter
      (
         .clk (clk),
         .rst (rst),
         .req (req_matrix[o]),
         .gnt (gnt_matrix[o])
      );
   end

   switch_traversal i_switch_traversal
   (
      .clk        (clk),
      .rst        (rst),
      .in_flit    (in_flit),
      .req_matrix (req_matrix),
      .gnt_matrix (gnt_matrix),
      .in_taken   (in_taken),
      .out_valid  (out_valid),
      .out_flit   (out_flit)
   );

endmodule

// ==== testbench/tb_clock_gen.sv ====
`timescale 1ns/1ps

module tb_clock_gen
(
   output logic clk,
   output logic rst
);

   // 4 ns period
   initial
   begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // Reset over the first 10 rising edges
   initial
   begin
      rst = 1'b1;
      repeat (10) @(posedge clk);
      #1;
      rst = 1'b0;
   end

endmodule

// ==== testbench/tb_mesh_router.sv ====
`timescale 1ns/1ps
`include "mesh_router_macros.svh"

module tb_mesh_router;

   import mesh_router_pkg::*;

   typedef struct packed {
      int        test;
      port_idx_t src;
      int        start;
      coord_t    dst_x;
      coord_t    dst_y;
      int        count;
      port_idx_t exp_port;
      logic      lat_chk;
   } pkt_t;

   // Expected flit, its packet, and its arrival cycle (-1 if not timed)
   typedef struct packed {
      int    id;
      int    due;
      flit_t flit;
   } exp_t;

   localparam int          NUM_PKTS  = 18;
   localparam int          NUM_TESTS = 4;
   localparam logic [31:0] LFSR_SEED = 32'ha82662bf;

   // Router at (2,2) with rows sorted by start cycle and then by source
   localparam pkt_t PKTS [NUM_PKTS] = '{
      // XY routing with each packet alone at an idle output
      '{1, PORT_LOCAL, 12, 3'd2, 3'd3, 1, PORT_NORTH, 1'b1},
      '{1, PORT_LOCAL, 16, 3'd3, 3'd2, 1, PORT_EAST,  1'b1},
      '{1, PORT_LOCAL, 20, 3'd2, 3'd1, 1, PORT_SOUTH, 1'b1},
      '{1, PORT_LOCAL, 24, 3'd1, 3'd2, 1, PORT_WEST,  1'b1},
      '{1, PORT_LOCAL, 28, 3'd2, 3'd2, 1, PORT_LOCAL, 1'b1},
      '{1, PORT_NORTH, 32, 3'd2, 3'd2, 1, PORT_LOCAL, 1'b1},
      '{1, PORT_EAST,  36, 3'd2, 3'd2, 1, PORT_LOCAL, 1'b1},
      '{1, PORT_SOUTH, 40, 3'd2, 3'd2, 1, PORT_LOCAL, 1'b1},
      '{1, PORT_WEST,  44, 3'd2, 3'd2, 1, PORT_LOCAL, 1'b1},
      // South waits for the whole West packet
      '{2, PORT_WEST,  52, 3'd6, 3'd0, 4, PORT_EAST,  1'b1},
      '{2, PORT_SOUTH, 54, 3'd3, 3'd5, 2, PORT_EAST,  1'b0},
      '{2, PORT_NORTH, 60, 3'd0, 3'd7, 3, PORT_WEST,  1'b1},
      // Two packets to one output in the same cycle
      '{3, PORT_NORTH, 70, 3'd2, 3'd0, 3, PORT_SOUTH, 1'b1},
      '{3, PORT_WEST,  70, 3'd2, 3'd1, 2, PORT_SOUTH, 1'b0},
      // Four inputs to four outputs at once
      '{4, PORT_LOCAL, 90, 3'd2, 3'd4, 3, PORT_NORTH, 1'b1},
      '{4, PORT_NORTH, 90, 3'd2, 3'd2, 2, PORT_LOCAL, 1'b1},
      '{4, PORT_EAST,  90, 3'd0, 3'd2, 4, PORT_WEST,  1'b1},
      '{4, PORT_WEST,  90, 3'd4, 3'd4, 2, PORT_EAST,  1'b1}
   };

   logic      clk;
   logic      rst;
   port_vec_t in_valid;
   flit_t     in_flit  [`MR_NUM_PORTS];
   port_vec_t in_taken;
   port_vec_t out_valid;
   flit_t     out_flit [`MR_NUM_PORTS];

   flit_t       pkt_flit  [NUM_PKTS][4];
   exp_t        exp_q     [`MR_NUM_PORTS][$];
   int          pkt_left  [NUM_PKTS];
   int          test_left [NUM_TESTS+1];
   int          test_err  [NUM_TESTS+1];
   logic [31:0] lfsr_state;
   int          cycle = 0;
   int          limit = 200;
   int          errors = 0;
   int          checks = 0;
   int          reset_err = 0;
   int          tests_done = 0;
   int          tests_passed = 0;

   tb_clock_gen i_tb_clock_gen
   (
      .clk (clk),
      .rst (rst)
   );

   mesh_router
   #(
      .x_pos (3'd2),
      .y_pos (3'd2)
   )
   i_mesh_router
   (
      .clk       (clk),
      .rst       (rst),
      .in_valid  (in_valid),
      .in_flit   (in_flit),
      .in_taken  (in_taken),
      .out_valid (out_valid),
      .out_flit  (out_flit)
   );

   ////////////////////////////////////////
   // Payloads
   ////////////////////////////////////////

   // Galois form of x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      if (s[0])
         return (s >> 1) ^ 32'h80200003;
      return s >> 1;
   endfunction

   function automatic payload_t next_payload();
      payload_t pay;
      for (int b = 0; b < `MR_PAYLOAD_W; b++)
      begin
         lfsr_state = lfsr_next(lfsr_state);
         pay[b] = lfsr_state[0];
      end
      return pay;
   endfunction

   ////////////////////////////////////////
   // Sources
   ////////////////////////////////////////

   // Walks the table for one input and holds each flit until in_taken is seen
   task automatic run_source(input port_idx_t p);
      logic taken;
      @(posedge clk);
      #1;
      for (int e = 0; e < NUM_PKTS; e++)
      begin
         if (PKTS[e].src == p)
         begin
            while (cycle < PKTS[e].start)
            begin
               @(posedge clk);
               #1;
            end
            for (int k = 0; k < PKTS[e].count; k++)
            begin
               in_valid[p] = 1'b1;
               in_flit[p]  = pkt_flit[e][k];
               taken = 1'b0;
               while (!taken)
               begin
                  @(negedge clk);
                  taken = in_taken[p];
                  @(posedge clk);
                  #1;
               end
            end
            in_valid[p] = 1'b0;
         end
      end
   endtask

   ////////////////////////////////////////
   // Scoreboards
   ////////////////////////////////////////

   function automatic void finish_packet(input int id);
      int t;
      t = PKTS[id].test;
      test_left[t]--;
      if (test_left[t] == 0)
      begin
         $display("test %0d done at cycle %0d with %0d errors", t, cycle, test_err[t]);
         tests_done++;
         if (test_err[t] == 0)
            tests_passed++;
      end
   endfunction

   always @(negedge clk)
   begin
      exp_t got;
      // Nothing taken or delivered before the first table flit
      if (cycle >= 1 && cycle < PKTS[0].start)
      begin
         assert (out_valid == '0)
         else
         begin
            $display("FAIL %0t out_valid expected %b got %b", $time, 5'b0, out_valid);
            errors++;
            reset_err++;
         end
         assert (in_taken == '0)
         else
         begin
            $display("FAIL %0t in_taken expected %b got %b", $time, 5'b0, in_taken);
            errors++;
            reset_err++;
         end
      end
      for (int o = 0; o < `MR_NUM_PORTS; o++)
      begin
         if (!rst && out_valid[o])
         begin
            assert (exp_q[o].size() > 0)
            else
            begin
               $display("Output %0d delivered a flit at %0t with none expected", o, $time);
               errors++;
            end
            if (exp_q[o].size() > 0)
            begin
               got = exp_q[o].pop_front();
               checks++;
               assert (out_flit[o] == got.flit)
               else
               begin
                  $display("FAIL %0t out_flit[%0d] expected %h got %h",
                           $time, o, got.flit, out_flit[o]);
                  errors++;
                  test_err[PKTS[got.id].test]++;
               end
               if (got.due >= 0)
               begin
                  assert (cycle == got.due)
                  else
                  begin
                     $display("FAIL %0t out_valid[%0d] rise cycle expected %0d got %0d",
                              $time, o, got.due, cycle);
                     errors++;
                     test_err[PKTS[got.id].test]++;
                  end
               end
               pkt_left[got.id]--;
               if (pkt_left[got.id] == 0)
                  finish_packet(got.id);
            end
         end
      end
   end

   // Cycle count and timeout
   always @(posedge clk)
   begin
      cycle <= cycle + 1;
      if (cycle >= limit)
      begin
         $display("Timeout after %0d cycles with %0d tests unfinished",
                  cycle, NUM_TESTS - tests_done);
         $display("Test FAILED");
         $finish;
      end
   end

   ////////////////////////////////////////
   // Main sequence
   ////////////////////////////////////////

   initial
   begin
      flit_t f;
      exp_t  ent;
      in_valid = '0;
      for (int p = 0; p < `MR_NUM_PORTS; p++)
         in_flit[p] = '0;
      lfsr_state = LFSR_SEED;
      for (int e = 0; e < NUM_PKTS; e++)
      begin
         limit += PKTS[e].start + PKTS[e].count;
         pkt_left[e] = PKTS[e].count;
         test_left[PKTS[e].test]++;
         for (int k = 0; k < PKTS[e].count; k++)
         begin
            // Body flits keep a zero dst that would route West
            f = '0;
            f.head = (k == 0);
            f.tail = (k == PKTS[e].count - 1);
            if (k == 0)
            begin
               f.dst_x = PKTS[e].dst_x;
               f.dst_y = PKTS[e].dst_y;
            end
            f.payload = next_payload();
            pkt_flit[e][k] = f;
            ent.id   = e;
            ent.due  = (k == 0 && PKTS[e].lat_chk) ? PKTS[e].start + 2 : -1;
            ent.flit = f;
            exp_q[PKTS[e].exp_port].push_back(ent);
         end
      end
      fork
         run_source(PORT_LOCAL);
         run_source(PORT_NORTH);
         run_source(PORT_EAST);
         run_source(PORT_SOUTH);
         run_source(PORT_WEST);
         begin
            // Heads on every input while rst is high, withdrawn before release
            @(posedge clk);
            #1;
            for (int p = 0; p < `MR_NUM_PORTS; p++)
            begin
               f = '0;
               f.head  = 1'b1;
               f.tail  = 1'b1;
               f.dst_x = coord_t'(p);
               f.dst_y = coord_t'(p);
               in_flit[p] = f;
            end
            in_valid = '1;
            while (cycle < 9)
            begin
               @(posedge clk);
               #1;
            end
            in_valid = '0;
            while (cycle < PKTS[0].start)
               @(posedge clk);
            $display("reset check done with %0d errors", reset_err);
         end
      join
      while (tests_done < NUM_TESTS)
         @(posedge clk);
      // Room for any stray flit to show up
      repeat (8) @(posedge clk);
      for (int o = 0; o < `MR_NUM_PORTS; o++)
      begin
         assert (exp_q[o].size() == 0)
         else
         begin
            $display("Output %0d never delivered %0d expected flits", o, exp_q[o].size());
            errors++;
         end
      end
      $display("%0d of %0d tests passed, %0d flits checked, %0d errors",
               tests_passed, NUM_TESTS, checks, errors);
      if (errors == 0 && tests_passed == NUM_TESTS)
         $display("Test OK");
      else
         $display("Test FAILED");
      $finish;
   end

endmodule

// ==== mesh_router.f ====
+incdir+verilog
verilog/mesh_router_pkg.sv
verilog/output_arbiter.sv
verilog/route_compute.sv
verilog/switch_traversal.sv
verilog/mesh_router.sv
testbench/tb_clock_gen.sv
testbench/tb_mesh_router.sv

// ==== Makefile ====
BIN  := obj_dir/Vtb_mesh_router
SRCS := $(shell grep -v '^+' mesh_router.f)

.PHONY: all run clean

all: run

$(BIN): mesh_router.f $(SRCS) verilog/mesh_router_macros.svh
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module tb_mesh_router -f mesh_router.f -o Vtb_mesh_router

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx 'Test OK'

clean:
	rm -rf obj_dir
